// ==== rv_cases.txt ====
# test <name> | p <instruction word> | s <store address> <store data> | end <illegal 0/1>
# program words load from address 0, stores are listed in the order they must happen
test alu
p ff900093
p 00300113
p 402081b3
p 10302023
p 4020d233
p 10402223
p 0020a2b3
p 10502423
p 0020b333
p 10602623
p 0f00c393
p 10702823
p 00100073
s 00000100 fffffff6
s 00000104 ffffffff
s 00000108 00000001
s 0000010c 00000000
s 00000110 ffffff09
end 0
test branch
p ff900093
p 00300113
p 00208463
p 00156513
p 00209463
p 00256513
p 0020c463
p 00456513
p 0020d463
p 00856513
p 0020e463
p 01056513
p 0020f463
p 02056513
p 00210463
p 0015e593
p 00211463
p 0025e593
p 00114463
p 0045e593
p 00115463
p 0085e593
p 00116463
p 0105e593
p 00117463
p 0205e593
p 20a02023
p 20b02223
p 00100073
s 00000200 00000019
s 00000204 00000026
end 0
test jump
p 123450b7
p 00001117
p 00c001ef
p 00100493
p 00200493
p 02d00213
p 000202e7
p 00300493
p 00300493
p 00300493
p 00300493
p 30102023
p 30202223
p 30302423
p 30502623
p 30902823
p 00100073
s 00000300 12345000
s 00000304 00001004
s 00000308 0000000c
s 0000030c 0000001c
s 00000310 00000000
end 0
test load
p 5a500093
p 18102023
p 00700013
p 18002103
p 000101b3
p 18302223
p 00100073
s 00000180 000005a5
s 00000184 000005a5
end 0
test illegal_sb
p 00100093
p 1c102023
p 1c100223
p 1c102423
p 00100073
s 000001c0 00000001
end 1

// ==== tb.f ====
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_ctrl.sv
rv_core.sv
tb_clk_gen.sv
rv_checker.sv
rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_decode.sv
      - rv_alu.sv
      - rv_regfile.sv
      - rv_ctrl.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - rv_checker.sv
      - rv_core_tb.sv

// ==== rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

  localparam int CYCLES_PER_WORD = 200;
  localparam int MEM_WORDS       = 256;

  logic                  clk, rst_n;
  logic [`RV_XLEN-1:0]   awaddr, wdata, araddr, rdata;
  logic [`RV_STRB_W-1:0] wstrb;
  logic [`RV_RESP_W-1:0] bresp, rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, halted, illegal;

  logic [`RV_XLEN-1:0] mem [MEM_WORDS];

  string               names [$];
  int                  prog_start [$], prog_len [$], st_start [$], st_len [$];
  bit                  ill [$];
  logic [`RV_XLEN-1:0] prog_words [$], st_addr [$], st_data [$];

  int cycles = 0;
  int limit = 0;

  tb_clk_gen clk_gen_i (.clk);

  rv_core rv_core_i (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready, .halted, .illegal
  );

  rv_checker checker_i (
    .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .halted, .illegal
  );

  // memory model driving its outputs 1 ns after the edge
  int                  ar_cnt, r_cnt, aw_cnt, w_cnt;
  bit                  r_pend, aw_have, w_have;
  logic [`RV_XLEN-1:0] rd_q, aw_q, w_q;

  always @(posedge clk) begin : mem_model
    logic                s_rst_n, s_arv, s_rr, s_awv, s_wv, s_br;
    logic [`RV_XLEN-1:0] s_araddr, s_awaddr, s_wdata;
    s_rst_n  = rst_n;
    s_arv    = arvalid;
    s_rr     = rready;
    s_awv    = awvalid;
    s_wv     = wvalid;
    s_br     = bready;
    s_araddr = araddr;
    s_awaddr = awaddr;
    s_wdata  = wdata;
    #1;
    if (!s_rst_n) begin
      reset_bus();
    end else begin
      if (arready && s_arv) begin
        arready = 1'b0;
        rd_q    = s_araddr;
        r_pend  = 1'b1;
      end else if (s_arv && !arready && !r_pend && !rvalid) begin
        if (ar_cnt == 0) begin
          arready = 1'b1;
          ar_cnt  = $urandom % 3;
        end else begin
          ar_cnt--;
        end
      end
      if (rvalid && s_rr) rvalid = 1'b0;
      if (r_pend && !rvalid) begin
        if (r_cnt == 0) begin
          rvalid = 1'b1;
          rdata  = mem[rd_q[9:2]]; // word addressed
          rresp  = `RV_RESP_OKAY;
          r_pend = 1'b0;
          r_cnt  = $urandom % 3;
        end else begin
          r_cnt--;
        end
      end
      if (awready && s_awv) begin
        awready = 1'b0;
        aw_have = 1'b1;
        aw_q    = s_awaddr;
      end else if (s_awv && !awready && !aw_have) begin
        if (aw_cnt == 0) begin
          awready = 1'b1;
          aw_cnt  = $urandom % 3;
        end else begin
          aw_cnt--;
        end
      end
      if (wready && s_wv) begin
        wready = 1'b0;
        w_have = 1'b1;
        w_q    = s_wdata;
      end else if (s_wv && !wready && !w_have) begin
        if (w_cnt == 0) begin
          wready = 1'b1;
          w_cnt  = $urandom % 4;
        end else begin
          w_cnt--;
        end
      end
      if (bvalid && s_br) bvalid = 1'b0;
      if (aw_have && w_have && !bvalid) begin
        mem[aw_q[9:2]] = w_q;
        bvalid  = 1'b1;
        bresp   = `RV_RESP_OKAY;
        aw_have = 1'b0;
        w_have  = 1'b0;
      end
    end
  end

  task automatic reset_bus();
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = `RV_RESP_OKAY;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = `RV_RESP_OKAY;
    r_pend  = 1'b0;
    aw_have = 1'b0;
    w_have  = 1'b0;
    ar_cnt  = $urandom % 3;
    r_cnt   = $urandom % 3;
    aw_cnt  = $urandom % 3;
    w_cnt   = $urandom % 3;
  endtask

  task automatic read_cases();
    int                  fd, code;
    string               line, key, nm;
    logic [`RV_XLEN-1:0] a, d;
    fd = $fopen("rv_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open rv_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        key  = "";
        code = $sscanf(line, "%s", key);
        if (code < 1 || key.len() == 0 || key[0] == "#") continue;
        if (key == "test") begin
          void'($sscanf(line, "%s %s", key, nm));
          names.push_back(nm);
          prog_start.push_back(prog_words.size());
          prog_len.push_back(0);
          st_start.push_back(st_addr.size());
          st_len.push_back(0);
          ill.push_back(1'b0);
        end else if (key == "p") begin
          void'($sscanf(line, "%s %h", key, d));
          prog_words.push_back(d);
          prog_len[prog_len.size()-1]++;
        end else if (key == "s") begin
          void'($sscanf(line, "%s %h %h", key, a, d));
          st_addr.push_back(a);
          st_data.push_back(d);
          st_len[st_len.size()-1]++;
        end else if (key == "end") begin
          void'($sscanf(line, "%s %h", key, d));
          ill[ill.size()-1] = d[0];
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_memory(input int t);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a00_00ff;
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      mem[(`RV_RESET_PC >> 2) + i] = prog_words[prog_start[t] + i];
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: core did not halt within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h6477_8817));
    rst_n = 1'b0;
    reset_bus();
    read_cases();
    if (names.size() == 0) begin
      $display("no test cases could be read from rv_cases.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      limit = CYCLES_PER_WORD * prog_words.size();
      for (int t = 0; t < names.size(); t++) begin
        @(posedge clk);
        #1 rst_n = 1'b0;
        load_memory(t);
        checker_i.start_test(names[t], ill[t]);
        for (int k = 0; k < st_len[t]; k++) begin
          checker_i.expect_store(st_addr[st_start[t] + k], st_data[st_start[t] + k]);
        end
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        while (!halted) @(posedge clk);
        wait (checker_i.tests_done > t);
      end
      $display("errors: %0d mismatches, %0d other", checker_i.mismatch_count,
               checker_i.other_count);
      if (checker_i.mismatch_count == 0 && checker_i.other_count == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== rv_checker.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic [`RV_XLEN-1:0]   awaddr,
  input logic                  awvalid,
  input logic                  awready,
  input logic [`RV_XLEN-1:0]   wdata,
  input logic [`RV_STRB_W-1:0] wstrb,
  input logic                  wvalid,
  input logic                  wready,
  input logic                  halted,
  input logic                  illegal
);

  string               test_name;
  logic [`RV_XLEN-1:0] exp_addr [$];
  logic [`RV_XLEN-1:0] exp_data [$];
  logic [`RV_XLEN-1:0] got_addr [$];
  logic [`RV_XLEN-1:0] got_data [$];
  bit                  exp_illegal;
  logic                halted_q;
  int                  store_idx;
  int                  mismatch_count = 0;
  int                  other_count = 0;
  int                  tests_done = 0;

  task automatic start_test(input string name, input bit ill);
    test_name   = name;
    exp_illegal = ill;
    store_idx   = 0;
    exp_addr.delete();
    exp_data.delete();
    got_addr.delete();
    got_data.delete();
  endtask

  task automatic expect_store(input logic [`RV_XLEN-1:0] addr, input logic [`RV_XLEN-1:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic compare_store(input logic [`RV_XLEN-1:0] addr, input logic [`RV_XLEN-1:0] data);
    logic [`RV_XLEN-1:0] ea;
    logic [`RV_XLEN-1:0] ed;
    if (exp_addr.size() == 0) begin
      other_count++;
      $display("%s: unexpected store of %h to %h after the expected stores", test_name,
               data, addr);
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      if (addr !== ea) begin
        mismatch_count++;
        $display("MISMATCH %s store %0d address: expected %h actual %h", test_name,
                 store_idx, ea, addr);
      end
      if (data !== ed) begin
        mismatch_count++;
        $display("MISMATCH %s store %0d data: expected %h actual %h", test_name,
                 store_idx, ed, data);
      end
    end
    store_idx++;
  endtask

  // called once the core has halted
  task automatic end_test();
    if (exp_addr.size() != 0) begin
      other_count++;
      $display("%s: %0d expected stores never happened", test_name, exp_addr.size());
    end
    if (got_addr.size() != got_data.size()) begin
      other_count++;
      $display("%s: a store has its address and data handshakes out of step", test_name);
    end
    if (illegal !== exp_illegal) begin
      other_count++;
      $display("%s: core halted with illegal flag %b but %b was expected", test_name,
               illegal, exp_illegal);
    end
    tests_done++;
  endtask

  // aw and w may complete on different cycles
  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) got_addr.push_back(awaddr);
      if (wvalid && wready) begin
        got_data.push_back(wdata);
        if (wstrb !== {(`RV_STRB_W){1'b1}}) begin
          mismatch_count++;
          $display("MISMATCH %s store %0d strobe: expected %h actual %h", test_name,
                   store_idx, {(`RV_STRB_W){1'b1}}, wstrb);
        end
      end
      if (got_addr.size() > 0 && got_data.size() > 0) begin
        compare_store(got_addr.pop_front(), got_data.pop_front());
      end
    end
  end

  // one report per test when halted rises
  always @(posedge clk) begin
    if (rst_n && halted && !halted_q) begin
      end_test();
    end
    halted_q = halted;
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk; // 10 ns period

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic [`RV_XLEN-1:0]   awaddr,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_STRB_W-1:0] wstrb,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic [`RV_RESP_W-1:0] bresp,
  input  logic                  bvalid,
  output logic                  bready,
  output logic [`RV_XLEN-1:0]   araddr,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [`RV_XLEN-1:0]   rdata,
  input  logic [`RV_RESP_W-1:0] rresp,
  input  logic                  rvalid,
  output logic                  rready,
  output logic                  halted,
  output logic                  illegal
);

  logic [`RV_XLEN-1:0]   inst, imm;
  logic [`RV_XLEN-1:0]   alu_a, alu_b, alu_result;
  logic [`RV_XLEN-1:0]   rs1_data, rs2_data, rf_wdata;
  logic [`RV_REG_AW-1:0] rf_waddr;
  logic                  rf_we, branch_taken;
  logic                  is_branch, is_jump, is_jalr, is_halt, is_illegal;
  rv_pkg::alu_op_e       alu_op;
  rv_pkg::src_sel_e      src_sel;
  rv_pkg::mem_op_e       mem_op;

  rv_ctrl ctrl_i (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready, .halted, .illegal, .inst,
    .src_sel, .mem_op, .imm, .is_branch, .is_jump, .is_jalr, .is_halt, .is_illegal,
    .alu_a, .alu_b, .alu_result, .branch_taken, .rs1_data, .rs2_data,
    .rf_we, .rf_waddr, .rf_wdata
  );

  rv_decode decode_i (
    .inst, .alu_op, .src_sel, .mem_op, .imm,
    .is_branch, .is_jump, .is_jalr, .is_halt, .is_illegal
  );

  rv_alu alu_i (
    .op           (alu_op),
    .a            (alu_a),
    .b            (alu_b),
    .funct3       (inst[14:12]),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_regfile regfile_i (
    .clk, .rst_n,
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd_addr  (rf_waddr),
    .rd_data  (rf_wdata)
  );

endmodule

// ==== rv_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic [`RV_XLEN-1:0]   awaddr,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_STRB_W-1:0] wstrb,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic [`RV_RESP_W-1:0] bresp,
  input  logic                  bvalid,
  output logic                  bready,
  output logic [`RV_XLEN-1:0]   araddr,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [`RV_XLEN-1:0]   rdata,
  input  logic [`RV_RESP_W-1:0] rresp,
  input  logic                  rvalid,
  output logic                  rready,
  output logic                  halted,
  output logic                  illegal,
  output logic [`RV_XLEN-1:0]   inst,
  input  rv_pkg::src_sel_e      src_sel,
  input  rv_pkg::mem_op_e       mem_op,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic                  is_branch,
  input  logic                  is_jump,
  input  logic                  is_jalr,
  input  logic                  is_halt,
  input  logic                  is_illegal,
  output logic [`RV_XLEN-1:0]   alu_a,
  output logic [`RV_XLEN-1:0]   alu_b,
  input  logic [`RV_XLEN-1:0]   alu_result,
  input  logic                  branch_taken,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  output logic                  rf_we,
  output logic [`RV_REG_AW-1:0] rf_waddr,
  output logic [`RV_XLEN-1:0]   rf_wdata
);

  rv_pkg::ctrl_state_e state;
  rv_pkg::opcode_e     opcode;
  logic [`RV_XLEN-1:0] pc, inst_q, addr_q, wdata_q;
  logic [`RV_XLEN-1:0] pc_plus4, pc_plus_imm, jalr_sum, next_pc;
  logic                aw_pend, w_pend;
  logic                rd_writes;

  assign opcode = rv_pkg::opcode_e'(inst_q[6:0]);
  assign inst   = inst_q;

  // operand select
  always_comb begin
    case (src_sel)
      rv_pkg::SRC_PC_IMM: begin
        alu_a = pc;
        alu_b = imm;
      end
      rv_pkg::SRC_PC_4: begin
        alu_a = pc;
        alu_b = 4;
      end
      rv_pkg::SRC_RS1_RS2: begin
        alu_a = rs1_data;
        alu_b = rs2_data;
      end
      default: begin
        alu_a = (opcode == rv_pkg::OPC_LUI) ? '0 : rs1_data; // lui adds imm to zero
        alu_b = imm;
      end
    endcase
  end

  assign pc_plus4    = pc + 4;
  assign pc_plus_imm = pc + imm;
  assign jalr_sum    = rs1_data + imm;

  always_comb begin
    if (is_jalr) begin
      next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else if (is_jump || (is_branch && branch_taken)) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // write-back
  assign rd_writes = (mem_op == rv_pkg::MEM_NONE) && !is_branch
                     && opcode != rv_pkg::OPC_FENCE && opcode != rv_pkg::OPC_SYS;
  assign rf_we     = (state == rv_pkg::ST_EXECUTE && !is_illegal && rd_writes)
                     || (state == rv_pkg::ST_LOAD_DATA && rvalid && rresp == `RV_RESP_OKAY);
  assign rf_waddr  = inst_q[11:7];
  assign rf_wdata  = (state == rv_pkg::ST_LOAD_DATA) ? rdata : alu_result;

  // axi master outputs
  assign arvalid = (state == rv_pkg::ST_FETCH_ADDR) || (state == rv_pkg::ST_LOAD_ADDR);
  assign araddr  = (state == rv_pkg::ST_LOAD_ADDR) ? addr_q : pc;
  assign rready  = (state == rv_pkg::ST_FETCH_DATA) || (state == rv_pkg::ST_LOAD_DATA);
  assign awvalid = aw_pend;
  assign awaddr  = addr_q;
  assign wvalid  = w_pend;
  assign wdata   = wdata_q;
  assign wstrb   = '1;
  assign bready  = (state == rv_pkg::ST_STORE_RESP);
  assign halted  = (state == rv_pkg::ST_HALT);

  always_ff @(posedge clk) begin
    if (state == rv_pkg::ST_FETCH_DATA && rvalid) begin
      inst_q <= rdata;
    end
    if (state == rv_pkg::ST_EXECUTE) begin
      addr_q  <= alu_result; // rs1 + imm
      wdata_q <= rs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rv_pkg::ST_FETCH_ADDR;
      pc      <= `RV_RESET_PC;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        rv_pkg::ST_FETCH_ADDR: begin
          if (arready) state <= rv_pkg::ST_FETCH_DATA;
        end
        rv_pkg::ST_FETCH_DATA: begin
          if (rvalid && rresp != `RV_RESP_OKAY) begin
            state   <= rv_pkg::ST_HALT;
            illegal <= 1'b1;
          end else if (rvalid) begin
            state <= rv_pkg::ST_EXECUTE;
          end
        end
        rv_pkg::ST_EXECUTE: begin
          if (is_illegal) begin
            state   <= rv_pkg::ST_HALT;
            illegal <= 1'b1;
          end else if (is_halt) begin
            state <= rv_pkg::ST_HALT;
          end else begin
            pc <= next_pc;
            case (mem_op)
              rv_pkg::MEM_LOAD: state <= rv_pkg::ST_LOAD_ADDR;
              rv_pkg::MEM_STORE: begin
                state   <= rv_pkg::ST_STORE_REQ;
                aw_pend <= 1'b1; // aw and w raised together
                w_pend  <= 1'b1;
              end
              default: state <= rv_pkg::ST_FETCH_ADDR;
            endcase
          end
        end
        rv_pkg::ST_LOAD_ADDR: begin
          if (arready) state <= rv_pkg::ST_LOAD_DATA;
        end
        rv_pkg::ST_LOAD_DATA: begin
          if (rvalid && rresp != `RV_RESP_OKAY) begin
            state   <= rv_pkg::ST_HALT;
            illegal <= 1'b1;
          end else if (rvalid) begin
            state <= rv_pkg::ST_FETCH_ADDR;
          end
        end
        rv_pkg::ST_STORE_REQ: begin
          if (awready) aw_pend <= 1'b0;
          if (wready) w_pend <= 1'b0;
          if ((awready || !aw_pend) && (wready || !w_pend)) begin
            state <= rv_pkg::ST_STORE_RESP;
          end
        end
        rv_pkg::ST_STORE_RESP: begin
          if (bvalid && bresp != `RV_RESP_OKAY) begin
            state   <= rv_pkg::ST_HALT;
            illegal <= 1'b1;
          end else if (bvalid) begin
            state <= rv_pkg::ST_FETCH_ADDR;
          end
        end
        default: state <= rv_pkg::ST_HALT; // left only by reset
      endcase
    end
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] rd_addr,
  input  logic [`RV_XLEN-1:0]   rd_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin // x0 never written
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
  input  rv_pkg::alu_op_e     op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  logic [2:0]          funct3,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [`RV_XLEN:0] diff;
  logic              lt_s, lt_u, eq;

  assign diff = {1'b0, a} - {1'b0, b};
  assign lt_u = diff[`RV_XLEN]; // borrow out
  assign lt_s = (a[`RV_XLEN-1] ^ b[`RV_XLEN-1]) ? a[`RV_XLEN-1] : diff[`RV_XLEN-1];
  assign eq   = (diff[`RV_XLEN-1:0] == '0);

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB,
      rv_pkg::ALU_SUBU: result = diff[`RV_XLEN-1:0];
      rv_pkg::ALU_SLL:  result = a << b[4:0];
      rv_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> b[4:0];
      rv_pkg::ALU_SRA:  result = $signed(a) >>> b[4:0];
      rv_pkg::ALU_OR:   result = a | b;
      default:          result = a & b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = !eq;
      3'b100:  branch_taken = lt_s;
      3'b101:  branch_taken = !lt_s;
      3'b110:  branch_taken = lt_u;
      3'b111:  branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0] inst,
  output rv_pkg::alu_op_e     alu_op,
  output rv_pkg::src_sel_e    src_sel,
  output rv_pkg::mem_op_e     mem_op,
  output logic [`RV_XLEN-1:0] imm,
  output logic                is_branch,
  output logic                is_jump,
  output logic                is_jalr,
  output logic                is_halt,
  output logic                is_illegal
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                alt_ok;
  logic                f7_checked;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct7 only matters for shifts and register ops
  assign f7_checked = (opcode == rv_pkg::OPC_OP) || (funct3[1:0] == 2'b01);
  assign alt_ok     = (funct3 == 3'b101) || (funct3 == 3'b000 && opcode == rv_pkg::OPC_OP);

  always_comb begin
    alu_op     = rv_pkg::ALU_ADD;
    src_sel    = rv_pkg::SRC_RS1_IMM;
    mem_op     = rv_pkg::MEM_NONE;
    imm        = imm_i;
    is_branch  = 1'b0;
    is_jump    = 1'b0;
    is_jalr    = 1'b0;
    is_halt    = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: imm = imm_u; // rs1 forced to zero in ctrl
      rv_pkg::OPC_AUIPC: begin
        src_sel = rv_pkg::SRC_PC_IMM;
        imm     = imm_u;
      end
      rv_pkg::OPC_JAL: begin
        src_sel = rv_pkg::SRC_PC_4; // link value from alu
        imm     = imm_j;
        is_jump = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        src_sel    = rv_pkg::SRC_PC_4;
        is_jump    = 1'b1;
        is_jalr    = 1'b1;
        is_illegal = (funct3 != 3'b000);
      end
      rv_pkg::OPC_BRANCH: begin
        src_sel    = rv_pkg::SRC_RS1_RS2;
        imm        = imm_b;
        is_branch  = 1'b1;
        alu_op     = funct3[1] ? rv_pkg::ALU_SUBU : rv_pkg::ALU_SUB;
        is_illegal = (funct3[2:1] == 2'b01);
      end
      rv_pkg::OPC_LOAD: begin
        mem_op     = rv_pkg::MEM_LOAD;
        is_illegal = (funct3 != 3'b010); // word only
      end
      rv_pkg::OPC_STORE: begin
        mem_op     = rv_pkg::MEM_STORE;
        imm        = imm_s;
        is_illegal = (funct3 != 3'b010);
      end
      rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
        if (opcode == rv_pkg::OPC_OP) begin
          src_sel = rv_pkg::SRC_RS1_RS2;
        end
        case (funct3)
          3'b000:  alu_op = (alt_ok && inst[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  alu_op = rv_pkg::ALU_SLL;
          3'b010:  alu_op = rv_pkg::ALU_SLT;
          3'b011:  alu_op = rv_pkg::ALU_SLTU;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          3'b101:  alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          default: alu_op = rv_pkg::ALU_AND;
        endcase
        is_illegal = f7_checked && !(funct7 == 7'b0 || (funct7 == 7'b0100000 && alt_ok));
      end
      rv_pkg::OPC_FENCE: ; // no-op
      rv_pkg::OPC_SYS: begin
        if (inst == 32'h0010_0073) begin
          is_halt = 1'b1; // ebreak
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: is_illegal = 1'b1;
    endcase
  end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_FENCE  = 7'b0001111,
    OPC_SYS    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SUBU, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // operand a / operand b
  typedef enum logic [1:0] {
    SRC_RS1_IMM, SRC_PC_IMM, SRC_PC_4, SRC_RS1_RS2
  } src_sel_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
  } mem_op_e;

  typedef enum logic [2:0] {
    ST_FETCH_ADDR, ST_FETCH_DATA, ST_EXECUTE, ST_LOAD_ADDR,
    ST_LOAD_DATA, ST_STORE_REQ, ST_STORE_RESP, ST_HALT
  } ctrl_state_e;

endpackage

// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural registers
`define RV_NREGS 32
`define RV_REG_AW 5

// axi response
`define RV_RESP_W 2
`define RV_RESP_OKAY 2'b00

// strobe width for one data word
`define RV_STRB_W (`RV_XLEN / 8)

`endif
